/* build.f */
hdl/spi_pkg.sv
hdl/spi_regs.sv
hdl/spi_master.sv
hdl/spi_slave.sv
hdl/parallella_spi.sv
testbench/tb_clock_gen.sv
testbench/tb_parallella_spi.sv

/* hdl/parallella_spi.sv */
// Parallella SPI top level
module parallella_spi #(
   parameter int NGPIO       = 24,               // Pin bank width, at least 11
   parameter int SYNC_STAGES = 2                 // Slave input sync depth
) (
   input  logic               sys_clk,
   input  logic               arst_n,
   input  logic               reg_wr,
   input  logic               reg_rd,
   input  spi_pkg::reg_addr_t reg_addr,
   input  spi_pkg::reg_data_t reg_wdata,
   output spi_pkg::reg_data_t reg_rdata,
   output logic               reg_rvalid,
   output logic               spi_irq,
   input  logic [NGPIO-1:0]   gpio_in,
   output logic [NGPIO-1:0]   gpio_out,
   output logic [NGPIO-1:0]   gpio_dir           // 1 = out
);

   logic               spi_m_sclk;
   logic               spi_m_mosi;
   logic               spi_m_ss;
   logic               spi_m_miso;
   logic               spi_s_sclk;
   logic               spi_s_mosi;
   logic               spi_s_ss;
   logic               spi_s_miso;
   logic               m_start;
   spi_pkg::spi_byte_t m_txbyte;
   logic [7:0]         m_div;
   logic               m_busy;
   logic               m_done;
   spi_pkg::spi_byte_t m_rxbyte;
   logic               s_en;
   spi_pkg::spi_byte_t s_txbyte;
   logic               s_rxstrobe;
   spi_pkg::spi_byte_t s_rxbyte;

   //############################
   // Pin mapping
   //############################
   assign spi_m_miso = gpio_in[spi_pkg::PIN_M_MISO];
   assign spi_s_sclk = gpio_in[spi_pkg::PIN_S_SCLK];
   assign spi_s_mosi = gpio_in[spi_pkg::PIN_S_MOSI];
   assign spi_s_ss   = gpio_in[spi_pkg::PIN_S_SS];
   assign gpio_dir   = NGPIO'(spi_pkg::GPIO_DIR_MASK);

   always_comb begin
      gpio_out                      = '0;        // Unused pins low
      gpio_out[spi_pkg::PIN_M_SCLK] = spi_m_sclk;
      gpio_out[spi_pkg::PIN_M_MOSI] = spi_m_mosi;
      gpio_out[spi_pkg::PIN_M_SS]   = spi_m_ss;
      gpio_out[spi_pkg::PIN_S_MISO] = spi_s_miso;
   end

   //############################
   // Blocks
   //############################
   spi_regs spi_regs (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid),
      .spi_irq    (spi_irq),
      .m_start    (m_start),
      .m_txbyte   (m_txbyte),
      .m_div      (m_div),
      .m_busy     (m_busy),
      .m_done     (m_done),
      .m_rxbyte   (m_rxbyte),
      .s_en       (s_en),
      .s_txbyte   (s_txbyte),
      .s_rxstrobe (s_rxstrobe),
      .s_rxbyte   (s_rxbyte)
   );

   spi_master spi_master (
      .sys_clk  (sys_clk),
      .arst_n   (arst_n),
      .m_start  (m_start),
      .m_txbyte (m_txbyte),
      .m_div    (m_div),
      .miso     (spi_m_miso),
      .sclk     (spi_m_sclk),
      .mosi     (spi_m_mosi),
      .ss       (spi_m_ss),
      .m_busy   (m_busy),
      .m_done   (m_done),
      .m_rxbyte (m_rxbyte)
   );

   spi_slave #(.SYNC_STAGES(SYNC_STAGES)) spi_slave (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .s_en       (s_en),
      .s_txbyte   (s_txbyte),
      .sclk       (spi_s_sclk),
      .mosi       (spi_s_mosi),
      .ss         (spi_s_ss),
      .miso       (spi_s_miso),
      .s_rxstrobe (s_rxstrobe),
      .s_rxbyte   (s_rxbyte)
   );

endmodule

/* hdl/spi_master.sv */
// SPI master shift engine
module spi_master (
   input  logic               sys_clk,
   input  logic               arst_n,
   input  logic               m_start,           // One cycle kick
   input  spi_pkg::spi_byte_t m_txbyte,
   input  logic [7:0]         m_div,             // Half period is m_div+1 cycles
   input  logic               miso,
   output logic               sclk,              // Mode 0, idles low
   output logic               mosi,
   output logic               ss,                // Active low
   output logic               m_busy,
   output logic               m_done,            // Pulse at end of frame
   output spi_pkg::spi_byte_t m_rxbyte
);

   logic [7:0]         div_cnt;                  // Cycles into half period
   logic [3:0]         half_cnt;                 // 16 halves per frame
   logic               tick;                     // Half period boundary
   logic               last_half;
   spi_pkg::spi_byte_t shreg;                    // TX out the top, RX in the bottom

   assign tick      = m_busy && (div_cnt >= m_div);
   assign last_half = (half_cnt == 4'd15);

   //############################
   // Frame control
   //############################
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         m_busy   <= 1'b0;
         m_done   <= 1'b0;
         ss       <= 1'b1;
         sclk     <= 1'b0;
         mosi     <= 1'b0;
         div_cnt  <= '0;
         half_cnt <= '0;
      end else begin
         m_done <= 1'b0;
         if (m_start && !m_busy) begin
            m_busy   <= 1'b1;
            ss       <= 1'b0;                    // SS low the cycle after start
            mosi     <= m_txbyte[7];             // MSB set up before first rise
            div_cnt  <= '0;
            half_cnt <= '0;
         end else if (tick) begin
            div_cnt  <= '0;
            sclk     <= ~sclk;
            half_cnt <= half_cnt + 4'd1;
            if (sclk) begin                      // Falling edge
               if (last_half) begin
                  m_busy <= 1'b0;
                  m_done <= 1'b1;
                  ss     <= 1'b1;
                  mosi   <= 1'b0;
               end else begin
                  mosi <= shreg[7];              // Next bit out
               end
            end
         end else if (m_busy) begin
            div_cnt <= div_cnt + 8'd1;
         end
      end
   end

   //############################
   // Shift datapath
   //############################
   always_ff @(posedge sys_clk) begin
      if (m_start && !m_busy)
         shreg <= m_txbyte;
      else if (tick && !sclk)
         shreg <= {shreg[6:0], miso};            // Sample on rising edge
      if (tick && sclk && last_half)
         m_rxbyte <= shreg;                      // Whole byte in by now
   end

endmodule

/* hdl/spi_pkg.sv */
// SPI peripheral definitions
package spi_pkg;

   //############################
   // Bus and frame types
   //############################
   typedef logic [5:0]  reg_addr_t;                   // Register byte address
   typedef logic [31:0] reg_data_t;                   // Register data word
   typedef logic [7:0]  spi_byte_t;                   // One SPI frame

   //############################
   // Register map
   //############################
   localparam reg_addr_t REG_CONFIG    = 6'h00;       // Enables, irq enable, divider
   localparam reg_addr_t REG_STATUS    = 6'h04;       // Busy, done, rx valid
   localparam reg_addr_t REG_MASTER_TX = 6'h08;       // Write starts a transfer
   localparam reg_addr_t REG_MASTER_RX = 6'h0C;       // Last byte from MISO
   localparam reg_addr_t REG_SLAVE_TX  = 6'h10;       // Reply byte for next frame
   localparam reg_addr_t REG_SLAVE_RX  = 6'h14;       // Read clears rx valid

   localparam int CFG_MASTER_EN  = 0;                 // CONFIG bits
   localparam int CFG_SLAVE_EN   = 1;
   localparam int CFG_IRQ_EN     = 2;
   localparam int CFG_DIV_LSB    = 8;                 // Divider in 15:8

   localparam int ST_MASTER_BUSY = 0;                 // STATUS bits
   localparam int ST_MASTER_DONE = 1;                 // Sticky, W1C
   localparam int ST_SLAVE_RXV   = 2;

   //############################
   // Pin bank
   //############################
   localparam int PIN_M_SCLK = 3;
   localparam int PIN_M_MOSI = 4;
   localparam int PIN_M_MISO = 5;
   localparam int PIN_M_SS   = 6;
   localparam int PIN_S_SCLK = 7;                     // Needs a clock capable pin
   localparam int PIN_S_MOSI = 8;
   localparam int PIN_S_MISO = 9;
   localparam int PIN_S_SS   = 10;

   localparam logic [23:0] GPIO_DIR_MASK = 24'h000258; // 1 = out, bits 3 4 6 9

endpackage

/* hdl/spi_regs.sv */
// SPI register block
module spi_regs (
   input  logic               sys_clk,
   input  logic               arst_n,
   input  logic               reg_wr,            // Write strobe
   input  logic               reg_rd,            // Read strobe
   input  spi_pkg::reg_addr_t reg_addr,
   input  spi_pkg::reg_data_t reg_wdata,
   output spi_pkg::reg_data_t reg_rdata,
   output logic               reg_rvalid,        // One cycle after reg_rd
   output logic               spi_irq,
   output logic               m_start,           // Pulse to master
   output spi_pkg::spi_byte_t m_txbyte,
   output logic [7:0]         m_div,             // SCLK half period minus one
   input  logic               m_busy,
   input  logic               m_done,            // Pulse at end of frame
   input  spi_pkg::spi_byte_t m_rxbyte,
   output logic               s_en,
   output spi_pkg::spi_byte_t s_txbyte,
   input  logic               s_rxstrobe,        // Pulse on 8th slave bit
   input  spi_pkg::spi_byte_t s_rxbyte
);

   logic               m_en;                     // CONFIG master enable
   logic               irq_en;                   // CONFIG irq enable
   logic               done_flag;                // Sticky master done
   logic               rxv_flag;                 // Slave byte waiting
   spi_pkg::spi_byte_t m_rx_q;                   // MASTER_RX
   spi_pkg::spi_byte_t s_rx_q;                   // SLAVE_RX
   spi_pkg::reg_data_t rd_mux;
   logic               wr_cfg;
   logic               wr_status;
   logic               wr_mtx;
   logic               wr_stx;
   logic               rd_srx;

   //############################
   // Access decode
   //############################
   assign wr_cfg    = reg_wr && (reg_addr == spi_pkg::REG_CONFIG);
   assign wr_status = reg_wr && (reg_addr == spi_pkg::REG_STATUS);
   assign wr_mtx    = reg_wr && (reg_addr == spi_pkg::REG_MASTER_TX);
   assign wr_stx    = reg_wr && (reg_addr == spi_pkg::REG_SLAVE_TX);
   assign rd_srx    = reg_rd && (reg_addr == spi_pkg::REG_SLAVE_RX);

   //############################
   // Registers and flags
   //############################
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         m_en       <= 1'b0;
         s_en       <= 1'b0;
         irq_en     <= 1'b0;
         m_div      <= '0;
         m_txbyte   <= '0;
         s_txbyte   <= '0;
         m_rx_q     <= '0;
         s_rx_q     <= '0;
         done_flag  <= 1'b0;
         rxv_flag   <= 1'b0;
         m_start    <= 1'b0;
         spi_irq    <= 1'b0;
         reg_rvalid <= 1'b0;
         reg_rdata  <= '0;
      end else begin
         if (wr_cfg) begin
            m_en   <= reg_wdata[spi_pkg::CFG_MASTER_EN];
            s_en   <= reg_wdata[spi_pkg::CFG_SLAVE_EN];
            irq_en <= reg_wdata[spi_pkg::CFG_IRQ_EN];
            m_div  <= reg_wdata[spi_pkg::CFG_DIV_LSB +: 8];
         end
         if (wr_stx)
            s_txbyte <= reg_wdata[7:0];                  // Used from next SS fall
         m_start <= 1'b0;
         if (wr_mtx && !m_busy && !m_start) begin        // Dropped while a frame runs
            m_txbyte <= reg_wdata[7:0];
            m_start  <= m_en;                            // Kick only when enabled
         end
         if (m_done) begin                               // Set wins over clear
            done_flag <= 1'b1;
            m_rx_q    <= m_rxbyte;
         end else if (wr_status && reg_wdata[spi_pkg::ST_MASTER_DONE]) begin
            done_flag <= 1'b0;                           // W1C
         end
         if (s_rxstrobe) begin
            rxv_flag <= 1'b1;
            s_rx_q   <= s_rxbyte;
         end else if (rd_srx) begin
            rxv_flag <= 1'b0;                            // Cleared by reading the byte
         end
         spi_irq    <= irq_en & (done_flag | rxv_flag);  // Level irq
         reg_rvalid <= reg_rd;
         if (reg_rd)
            reg_rdata <= rd_mux;
      end
   end

   //############################
   // Read mux
   //############################
   always_comb begin
      rd_mux = '0;                                       // Unmapped reads zero
      case (reg_addr)
         spi_pkg::REG_CONFIG: begin
            rd_mux[spi_pkg::CFG_MASTER_EN]    = m_en;
            rd_mux[spi_pkg::CFG_SLAVE_EN]     = s_en;
            rd_mux[spi_pkg::CFG_IRQ_EN]       = irq_en;
            rd_mux[spi_pkg::CFG_DIV_LSB +: 8] = m_div;
         end
         spi_pkg::REG_STATUS: begin
            rd_mux[spi_pkg::ST_MASTER_BUSY] = m_busy | m_start | m_done; // Until done flag
            rd_mux[spi_pkg::ST_MASTER_DONE] = done_flag;
            rd_mux[spi_pkg::ST_SLAVE_RXV]   = rxv_flag;
         end
         spi_pkg::REG_MASTER_TX: rd_mux[7:0] = m_txbyte;
         spi_pkg::REG_MASTER_RX: rd_mux[7:0] = m_rx_q;
         spi_pkg::REG_SLAVE_TX:  rd_mux[7:0] = s_txbyte;
         spi_pkg::REG_SLAVE_RX:  rd_mux[7:0] = s_rx_q;
         default:                rd_mux      = '0;
      endcase
   end

endmodule

/* hdl/spi_slave.sv */
// SPI slave shift engine
module spi_slave #(
   parameter int SYNC_STAGES = 2                 // 2 or 3
) (
   input  logic               sys_clk,
   input  logic               arst_n,
   input  logic               s_en,
   input  spi_pkg::spi_byte_t s_txbyte,          // Reply for next frame
   input  logic               sclk,              // Async pins
   input  logic               mosi,
   input  logic               ss,
   output logic               miso,
   output logic               s_rxstrobe,        // Pulse on 8th bit
   output spi_pkg::spi_byte_t s_rxbyte
);

   logic [SYNC_STAGES-1:0][2:0] sync_q;          // {ss, mosi, sclk} per stage
   logic               ss_s;
   logic               mosi_s;
   logic               sclk_s;
   logic               sclk_d;                   // Previous synced SCLK
   logic               sclk_rise;
   logic               sclk_fall;
   logic               active;                   // Enabled and selected
   logic [2:0]         bit_cnt;
   spi_pkg::spi_byte_t tx_shreg;
   spi_pkg::spi_byte_t rx_shreg;

   //############################
   // Sync and edge detect
   //############################
   assign {ss_s, mosi_s, sclk_s} = sync_q[SYNC_STAGES-1];
   assign sclk_rise = sclk_s & ~sclk_d;
   assign sclk_fall = ~sclk_s & sclk_d;
   assign active    = s_en & ~ss_s;

   // Next bit goes out while the fall is being registered, which buys the
   // master one cycle of setup at slow dividers
   assign miso = !active ? 1'b1 : (sclk_fall ? tx_shreg[6] : tx_shreg[7]);

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q     <= {SYNC_STAGES{3'b100}};    // SS high, rest low
         sclk_d     <= 1'b0;
         bit_cnt    <= '0;
         s_rxstrobe <= 1'b0;
      end else begin
         sync_q     <= {sync_q[SYNC_STAGES-2:0], {ss, mosi, sclk}};
         sclk_d     <= sclk_s;
         s_rxstrobe <= 1'b0;
         if (!active) begin
            bit_cnt <= '0;                       // Frame restarts on next SS fall
         end else if (sclk_rise) begin
            bit_cnt    <= bit_cnt + 3'd1;
            s_rxstrobe <= (bit_cnt == 3'd7);
         end
      end
   end

   //############################
   // Shift datapath
   //############################
   always_ff @(posedge sys_clk) begin
      if (!active)
         tx_shreg <= s_txbyte;                   // Preload while idle
      else if (sclk_fall)
         tx_shreg <= {tx_shreg[6:0], 1'b1};      // Advance MISO
      if (sclk_rise)
         rx_shreg <= {rx_shreg[6:0], mosi_s};    // Sample MOSI
      if (active && sclk_rise && (bit_cnt == 3'd7))
         s_rxbyte <= {rx_shreg[6:0], mosi_s};
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_parallella_spi -o sim_parallella_spi
./obj_dir/sim_parallella_spi 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
   echo "Simulation FAILED, see sim.log"
   exit 1
fi
echo "Simulation OK"

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset
module tb_clock_gen #(
   parameter int PERIOD       = 100,              // sys_clk period
   parameter int RESET_CYCLES = 2                 // Rising edges held in reset
) (
   output logic sys_clk,
   output logic arst_n
);

   initial begin
      sys_clk = 1'b0;
      forever #(PERIOD / 2) sys_clk = ~sys_clk;
   end

   initial begin
      arst_n = 1'b0;                              // Asserted from time zero
      repeat (RESET_CYCLES) @(posedge sys_clk);
      #10 arst_n = 1'b1;                          // Released off the edge
   end

endmodule

/* testbench/tb_parallella_spi.sv */
// SPI peripheral testbench
module tb_parallella_spi;

   localparam int NGPIO          = 24;
   localparam int DIV            = 3;               // Smallest divider the slave follows
   localparam int DRIVE_DLY      = 10;              // Input skew after rising edge
   localparam int TIMEOUT_CYCLES = 20 * 16 * (DIV + 1) + 2000;

   logic               sys_clk;
   logic               arst_n;
   logic               reg_wr;
   logic               reg_rd;
   spi_pkg::reg_addr_t reg_addr;
   spi_pkg::reg_data_t reg_wdata;
   spi_pkg::reg_data_t reg_rdata;
   logic               reg_rvalid;
   logic               spi_irq;
   logic [NGPIO-1:0]   gpio_in;
   logic [NGPIO-1:0]   gpio_out;
   logic [NGPIO-1:0]   gpio_dir;
   int                 seed;                        // $random state
   int                 cycle_cnt;                   // Watchdog

   tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) clk_gen_i (
      .sys_clk (sys_clk),
      .arst_n  (arst_n)
   );

   parallella_spi #(.NGPIO(NGPIO), .SYNC_STAGES(2)) dut_i (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid),
      .spi_irq    (spi_irq),
      .gpio_in    (gpio_in),
      .gpio_out   (gpio_out),
      .gpio_dir   (gpio_dir)
   );

   // Master SCLK MOSI SS onto slave pins 7 8 10, slave MISO 9 back onto 5
   assign gpio_in = {13'b0, gpio_out[spi_pkg::PIN_M_SS], 1'b0, gpio_out[spi_pkg::PIN_M_MOSI],
                     gpio_out[spi_pkg::PIN_M_SCLK], 1'b0, gpio_out[spi_pkg::PIN_S_MISO], 5'b0};

   //############################
   // Error handling and watchdog
   //############################
   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_data(input spi_pkg::reg_data_t got, input spi_pkg::reg_data_t exp,
                             input string msg);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
         abort_run();
      end
   endtask

   task automatic check_byte(input spi_pkg::spi_byte_t got, input spi_pkg::spi_byte_t exp,
                             input string msg);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
         abort_run();
      end
   endtask

   always @(posedge sys_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", cycle_cnt);
         abort_run();
      end
   end

   //############################
   // Register port access
   //############################
   task automatic reg_write(input spi_pkg::reg_addr_t addr, input spi_pkg::reg_data_t data);
      @(posedge sys_clk);
      #DRIVE_DLY;
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge sys_clk);                           // Write lands here
      #DRIVE_DLY;
      reg_wr    = 1'b0;
   endtask

   task automatic reg_read(input spi_pkg::reg_addr_t addr, output spi_pkg::reg_data_t data);
      @(posedge sys_clk);
      #DRIVE_DLY;
      reg_rd   = 1'b1;
      reg_addr = addr;
      check_bit(reg_rvalid, 1'b0, "reg_rvalid low in strobe cycle");
      @(posedge sys_clk);
      #DRIVE_DLY;
      reg_rd   = 1'b0;
      check_bit(reg_rvalid, 1'b1, "reg_rvalid one cycle after reg_rd");
      data = reg_rdata;
   endtask

   task automatic wait_master_idle(output spi_pkg::reg_data_t status);
      reg_read(spi_pkg::REG_STATUS, status);
      while (status[0])                              // Busy bit
         reg_read(spi_pkg::REG_STATUS, status);
   endtask

   // CONFIG layout: master 0, slave 1, irq 2, divider 15:8
   function automatic spi_pkg::reg_data_t config_word(input logic m_en, input logic s_en,
                                                      input logic irq_en, input int div);
      config_word = {16'h0, 8'(div), 5'b0, irq_en, s_en, m_en};
   endfunction

   task automatic run_transfer(input spi_pkg::spi_byte_t m_byte, input spi_pkg::spi_byte_t s_byte,
                               output spi_pkg::reg_data_t status);
      reg_write(spi_pkg::REG_SLAVE_TX, {24'h0, s_byte});
      reg_write(spi_pkg::REG_MASTER_TX, {24'h0, m_byte});
      wait_master_idle(status);
   endtask

   //############################
   // Directed tests
   //############################
   task automatic reset_values();
      spi_pkg::reg_data_t rd;
      check_data({8'h0, gpio_dir}, 32'h0000_0258, "gpio_dir after reset");  // Bits 3 4 6 9
      check_data({8'h0, gpio_out}, 32'h0000_0240, "gpio_out after reset");  // SS and MISO high
      check_bit(gpio_out[6], 1'b1, "master SS idle high");
      check_bit(gpio_out[9], 1'b1, "slave MISO idle high");
      check_bit(gpio_out[3], 1'b0, "master SCLK idle low");
      check_bit(gpio_out[4], 1'b0, "master MOSI idle low");
      check_bit(spi_irq, 1'b0, "spi_irq after reset");
      check_bit(reg_rvalid, 1'b0, "reg_rvalid before any read");
      reg_read(6'h00, rd);
      @(posedge sys_clk);
      #DRIVE_DLY;
      check_bit(reg_rvalid, 1'b0, "reg_rvalid lasts one cycle");
      for (int a = 0; a <= 'h14; a += 4) begin   // All six registers
         reg_read(spi_pkg::reg_addr_t'(a), rd);
         check_data(rd, 32'h0, "register value after reset");
      end
   endtask

   task automatic register_access();
      spi_pkg::reg_data_t rd;
      spi_pkg::reg_data_t wr;
      reg_write(6'h00, 32'hFFFF_FFFF);
      reg_read(6'h00, rd);
      check_data(rd, 32'h0000_FF07, "CONFIG all ones");   // Only defined fields
      wr = $random(seed);
      reg_write(6'h00, wr);
      reg_read(6'h00, rd);
      check_data(rd, wr & 32'h0000_FF07, "CONFIG random");
      reg_write(6'h00, 32'h0);
      reg_write(6'h18, 32'hFFFF_FFFF);              // Unmapped
      reg_read(6'h18, rd);
      check_data(rd, 32'h0, "unmapped offset 0x18");
      reg_read(6'h3C, rd);
      check_data(rd, 32'h0, "unmapped offset 0x3C");
   endtask

   task automatic full_duplex_loopback();
      spi_pkg::spi_byte_t m_byte;
      spi_pkg::spi_byte_t s_byte;
      spi_pkg::reg_data_t st;
      spi_pkg::reg_data_t rd;
      reg_write(6'h00, config_word(1'b1, 1'b1, 1'b0, DIV));
      for (int i = 0; i < 10; i++) begin
         m_byte = spi_pkg::spi_byte_t'($random(seed));
         s_byte = spi_pkg::spi_byte_t'($random(seed));
         run_transfer(m_byte, s_byte, st);
         check_data(st, 32'h6, "STATUS done and rx valid");
         reg_read(6'h0C, rd);
         check_byte(rd[7:0], s_byte, "MASTER_RX holds slave byte");
         reg_read(6'h14, rd);
         check_byte(rd[7:0], m_byte, "SLAVE_RX holds master byte");
         reg_write(6'h04, 32'h2);                    // Clear done
      end
   endtask

   task automatic busy_protection();
      spi_pkg::spi_byte_t m_byte;
      spi_pkg::spi_byte_t s_byte;
      spi_pkg::reg_data_t st;
      spi_pkg::reg_data_t rd;
      m_byte = spi_pkg::spi_byte_t'($random(seed));
      s_byte = spi_pkg::spi_byte_t'($random(seed));
      reg_write(6'h10, {24'h0, s_byte});
      reg_write(6'h08, {24'h0, m_byte});
      reg_write(6'h08, {24'h0, ~m_byte});            // Lands mid frame
      reg_read(6'h08, rd);
      check_byte(rd[7:0], m_byte, "MASTER_TX keeps first byte");
      wait_master_idle(st);
      check_data(st, 32'h6, "STATUS after guarded frame");
      reg_read(6'h0C, rd);
      check_byte(rd[7:0], s_byte, "MASTER_RX after busy write");
      reg_read(6'h14, rd);
      check_byte(rd[7:0], m_byte, "SLAVE_RX from first write only");
      reg_write(6'h04, 32'h2);
      reg_read(6'h04, rd);
      check_data(rd, 32'h0, "no second frame started");
   endtask

   task automatic interrupt_flow();
      spi_pkg::spi_byte_t m_byte;
      spi_pkg::reg_data_t st;
      spi_pkg::reg_data_t rd;
      m_byte = spi_pkg::spi_byte_t'($random(seed));
      run_transfer(m_byte, 8'h5A, st);               // Irq enable still off
      check_bit(spi_irq, 1'b0, "spi_irq masked");
      reg_read(6'h14, rd);
      reg_write(6'h04, 32'h2);
      reg_write(6'h00, config_word(1'b1, 1'b1, 1'b1, DIV));
      reg_read(6'h04, rd);
      check_data(rd, 32'h0, "flags clear before irq frame");
      check_bit(spi_irq, 1'b0, "spi_irq with no flag set");
      run_transfer(m_byte, 8'hA5, st);
      check_data(st, 32'h6, "STATUS after irq frame");
      check_bit(spi_irq, 1'b1, "spi_irq after transfer");
      reg_write(6'h04, 32'h2);
      reg_read(6'h04, rd);
      check_data(rd, 32'h4, "rx valid still pending");
      check_bit(spi_irq, 1'b1, "spi_irq held by rx valid");
      reg_read(6'h14, rd);
      check_byte(rd[7:0], m_byte, "SLAVE_RX in irq test");
      reg_read(6'h04, rd);
      check_data(rd, 32'h0, "all flags cleared");
      check_bit(spi_irq, 1'b0, "spi_irq after clearing both");
   endtask

   task automatic slave_disabled();
      spi_pkg::reg_data_t st;
      spi_pkg::reg_data_t rd;
      reg_write(6'h00, config_word(1'b1, 1'b0, 1'b0, DIV));
      run_transfer(spi_pkg::spi_byte_t'($random(seed)), 8'h3C, st);
      check_data(st, 32'h2, "STATUS done without rx valid");
      reg_read(6'h0C, rd);
      check_byte(rd[7:0], 8'hFF, "MASTER_RX from idle MISO");
      reg_write(6'h04, 32'h2);
   endtask

   //############################
   // Main sequence
   //############################
   initial begin
      seed      = 32'h88ae;
      cycle_cnt = 0;
      reg_wr    = 1'b0;
      reg_rd    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      wait (arst_n === 1'b1);
      reset_values();
      register_access();
      full_duplex_loopback();
      busy_protection();
      interrupt_flow();
      slave_disabled();
      $display("Regression passed");
      $finish;
   end

endmodule
